//--- src/cnn_dim_pkg.sv
// CNN receiver geometry, data widths and the packed beat and write records
package cnn_dim_pkg;

    // Conv output geometry, 8x8 pixels by 4 channels
    localparam int CONV_DIM    = 8;
    localparam int NUM_LANES   = 4;
    localparam int POOL_DIM    = CONV_DIM / 2;
    localparam int POOL_WORDS  = POOL_DIM * POOL_DIM;
    localparam int NUM_CLASSES = 10;

    // MAC accumulator and feature word widths
    localparam int ACC_W  = 18;
    localparam int DATA_W = 16;

    // Counter and address widths derived from the geometry
    localparam int PIX_W   = $clog2(CONV_DIM);
    localparam int POOL_AW = $clog2(POOL_WORDS);
    localparam int CLASS_W = $clog2(NUM_CLASSES);
    localparam int LANE_W  = $clog2(NUM_LANES);

    // Lane k sits at index k of the packed array
    typedef logic [NUM_LANES-1:0][ACC_W-1:0]  lane_acc_t;
    typedef logic [NUM_LANES-1:0][DATA_W-1:0] lane_data_t;

    // One result beat from the MAC array
    typedef struct packed {
        logic      valid;
        lane_acc_t acc;
    } mac_beat_t;

    // One feature-map memory write of 4 lanes
    typedef struct packed {
        logic               en;
        logic [POOL_AW-1:0] addr;
        lane_data_t         data;
    } fmap_wr_t;

    // Current beat closes a 2x2 window at this pooled address
    typedef struct packed {
        logic               fire;
        logic [POOL_AW-1:0] addr;
    } pool_pos_t;

endpackage

//--- src/cnn_ctrl_pkg.sv
// CNN receiver control encodings and bias memory address map
package cnn_ctrl_pkg;

    // Receiving FSM states, the state also names the active layer
    typedef enum logic [1:0] {
        CONV_PROCESS = 2'd0,
        FC_PROCESS   = 2'd1,
        CLASSIFY     = 2'd2
    } rcv_state_e;

    // Bias memory holds one 4-lane word per address
    localparam int BIAS_AW = 4;

    // Conv biases, one word for all 4 channels
    localparam logic [BIAS_AW-1:0] BIAS_CONV_ADDR = 4'd0;

    // Classifier biases, 4 classes per word starting here
    localparam logic [BIAS_AW-1:0] BIAS_FC_BASE = 4'd1;

endpackage

//--- src/rcv_sequencer.sv
// Receiving FSM with pixel and class counters, window detection and bias addressing
`timescale 1ns/100ps

module rcv_sequencer
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                mac_valid_i,
    output logic [cnn_ctrl_pkg::BIAS_AW-1:0]    bias_addr_o,
    output cnn_dim_pkg::pool_pos_t              pool_pos_o,
    output logic                                score_we_o,
    output logic [cnn_dim_pkg::CLASS_W-1:0]     score_idx_o,
    output logic                                classify_start_o,
    output logic                                conv_phase_o
);

    cnn_ctrl_pkg::rcv_state_e state;

    // Raster position of the next conv pixel, x runs fastest
    logic [cnn_dim_pkg::PIX_W-1:0] x_cnt;
    logic [cnn_dim_pkg::PIX_W-1:0] y_cnt;

    // Index of the next class score
    logic [cnn_dim_pkg::CLASS_W-1:0] class_cnt;

    logic x_last;
    logic y_last;
    logic class_last;

    assign x_last     = (x_cnt == cnn_dim_pkg::PIX_W'(cnn_dim_pkg::CONV_DIM - 1));
    assign y_last     = (y_cnt == cnn_dim_pkg::PIX_W'(cnn_dim_pkg::CONV_DIM - 1));
    assign class_last = (class_cnt == cnn_dim_pkg::CLASS_W'(cnn_dim_pkg::NUM_CLASSES - 1));

    // State and counters move only on accepted beats, CLASSIFY lasts one cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= cnn_ctrl_pkg::CONV_PROCESS;
            x_cnt     <= '0;
            y_cnt     <= '0;
            class_cnt <= '0;
        end
        else
        begin
            case (state)
                cnn_ctrl_pkg::CONV_PROCESS:
                begin
                    if (mac_valid_i)
                    begin
                        if (x_last)
                        begin
                            x_cnt <= '0;
                            if (y_last)
                            begin
                                y_cnt <= '0;
                                state <= cnn_ctrl_pkg::FC_PROCESS;
                            end
                            else
                            begin
                                y_cnt <= y_cnt + 1'b1;
                            end
                        end
                        else
                        begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                end

                cnn_ctrl_pkg::FC_PROCESS:
                begin
                    if (mac_valid_i)
                    begin
                        if (class_last)
                        begin
                            class_cnt <= '0;
                            state     <= cnn_ctrl_pkg::CLASSIFY;
                        end
                        else
                        begin
                            class_cnt <= class_cnt + 1'b1;
                        end
                    end
                end

                cnn_ctrl_pkg::CLASSIFY:
                begin
                    state <= cnn_ctrl_pkg::CONV_PROCESS;
                end

                default:
                begin
                    state <= cnn_ctrl_pkg::CONV_PROCESS;
                end
            endcase
        end
    end

    // Start pulse follows the CLASSIFY cycle by one edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            classify_start_o <= 1'b0;
        end
        else
        begin
            classify_start_o <= (state == cnn_ctrl_pkg::CLASSIFY);
        end
    end

    assign conv_phase_o = (state == cnn_ctrl_pkg::CONV_PROCESS);

    // Odd x and odd y close the window whose top left pixel is (x-1, y-1)
    assign pool_pos_o.fire = conv_phase_o & mac_valid_i & x_cnt[0] & y_cnt[0];
    assign pool_pos_o.addr = cnn_dim_pkg::POOL_AW'((y_cnt >> 1) * cnn_dim_pkg::POOL_DIM
                                                   + (x_cnt >> 1));

    assign score_we_o  = (state == cnn_ctrl_pkg::FC_PROCESS) & mac_valid_i;
    assign score_idx_o = class_cnt;

    // Four class biases share one word
    always_comb
    begin
        case (state)
            cnn_ctrl_pkg::FC_PROCESS:
            begin
                bias_addr_o = cnn_ctrl_pkg::BIAS_FC_BASE
                            + cnn_ctrl_pkg::BIAS_AW'(class_cnt >> cnn_dim_pkg::LANE_W);
            end
            default:
            begin
                bias_addr_o = cnn_ctrl_pkg::BIAS_CONV_ADDR;
            end
        endcase
    end

endmodule

//--- src/bias_relu_pool.sv
// Conv pixel bias add and ReLU, line buffer and 2x2 average pooling into feature-map writes
`timescale 1ns/100ps

module bias_relu_pool
(
    input  logic                    clk,
    input  logic                    rst,
    input  cnn_dim_pkg::mac_beat_t  beat_i,
    input  cnn_dim_pkg::lane_data_t bias_i,
    input  cnn_dim_pkg::pool_pos_t  pool_pos_i,
    output cnn_dim_pkg::fmap_wr_t   fmap_wr_o
);

    // Rectified pixel vector of the current beat
    cnn_dim_pkg::lane_data_t pix_new;

    // Entry k holds the pixel accepted k+1 beats ago
    cnn_dim_pkg::lane_data_t line_buf [cnn_dim_pkg::CONV_DIM+1];

    // Average of the window closed by the current beat
    cnn_dim_pkg::lane_data_t pool_avg;

    // Registered write toward the feature-map memory
    logic                            wr_en_q;
    logic [cnn_dim_pkg::POOL_AW-1:0] wr_addr_q;
    cnn_dim_pkg::lane_data_t         wr_data_q;

    // Low 16 accumulator bits plus bias wrap, negative values clamp to 0
    always_comb
    begin
        logic [cnn_dim_pkg::DATA_W-1:0] sum;
        for (int k = 0; k < cnn_dim_pkg::NUM_LANES; k++)
        begin
            sum = beat_i.acc[k][cnn_dim_pkg::DATA_W-1:0] + bias_i[k];
            if (sum[cnn_dim_pkg::DATA_W-1])
            begin
                pix_new[k] = '0;
            end
            else
            begin
                pix_new[k] = sum;
            end
        end
    end

    // Left neighbor is one beat back, the row above is CONV_DIM and CONV_DIM+1 back
    always_comb
    begin
        logic [cnn_dim_pkg::DATA_W+1:0] win_sum;
        for (int k = 0; k < cnn_dim_pkg::NUM_LANES; k++)
        begin
            win_sum = pix_new[k]
                    + line_buf[0][k]
                    + line_buf[cnn_dim_pkg::CONV_DIM-1][k]
                    + line_buf[cnn_dim_pkg::CONV_DIM][k];
            pool_avg[k] = win_sum[cnn_dim_pkg::DATA_W+1:2];
        end
    end

    // Shift on every accepted beat
    always_ff @(posedge clk)
    begin
        if (beat_i.valid)
        begin
            line_buf[0] <= pix_new;
            for (int k = 1; k <= cnn_dim_pkg::CONV_DIM; k++)
            begin
                line_buf[k] <= line_buf[k-1];
            end
        end
    end

    // Write strobe, one cycle after the window's last pixel
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_en_q <= 1'b0;
        end
        else
        begin
            wr_en_q <= pool_pos_i.fire;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pool_pos_i.fire)
        begin
            wr_addr_q <= pool_pos_i.addr;
            wr_data_q <= pool_avg;
        end
    end

    assign fmap_wr_o.en   = wr_en_q;
    assign fmap_wr_o.addr = wr_addr_q;
    assign fmap_wr_o.data = wr_data_q;

endmodule

//--- src/score_argmax.sv
// Class score bank and four-stage argmax pipeline for the digit decision
`timescale 1ns/100ps

module score_argmax
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic [cnn_dim_pkg::ACC_W-1:0]       acc_i,
    input  logic [cnn_dim_pkg::DATA_W-1:0]      bias_i,
    input  logic                                score_we_i,
    input  logic [cnn_dim_pkg::CLASS_W-1:0]     score_idx_i,
    input  logic                                classify_start_i,
    output logic [cnn_dim_pkg::CLASS_W-1:0]     digit_o,
    output logic                                digit_valid_o
);

    // Candidate carried down the tree, value travels with its index
    typedef struct packed {
        logic [cnn_dim_pkg::CLASS_W-1:0]      idx;
        logic signed [cnn_dim_pkg::DATA_W-1:0] val;
    } cand_t;

    logic signed [cnn_dim_pkg::DATA_W-1:0] score_q [cnn_dim_pkg::NUM_CLASSES];

    cand_t s1_win [5];
    cand_t s1_next [5];
    cand_t s2_win [2];
    cand_t s2_tail;
    cand_t s3_win;
    cand_t s3_tail;
    cand_t s4_win;
    logic  s1_valid;
    logic  s2_valid;
    logic  s3_valid;
    logic  s4_valid;

    // Later index wins on equal scores
    function automatic cand_t pick_later(cand_t early, cand_t late);
        if (late.val >= early.val)
        begin
            return late;
        end
        return early;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int k = 0; k < cnn_dim_pkg::NUM_CLASSES; k++)
            begin
                score_q[k] <= '0;
            end
        end
        else if (score_we_i)
        begin
            for (int k = 0; k < cnn_dim_pkg::NUM_CLASSES; k++)
            begin
                if (score_idx_i == cnn_dim_pkg::CLASS_W'(k))
                begin
                    score_q[k] <= acc_i[cnn_dim_pkg::DATA_W-1:0] + bias_i;
                end
            end
        end
    end

    // Stage 1 pairs (0,1) (2,3) (4,5) (6,7) (8,9)
    always_comb
    begin
        for (int p = 0; p < 5; p++)
        begin
            s1_next[p] = pick_later('{idx: cnn_dim_pkg::CLASS_W'(2*p),   val: score_q[2*p]},
                                    '{idx: cnn_dim_pkg::CLASS_W'(2*p+1), val: score_q[2*p+1]});
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            s4_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= classify_start_i;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            s4_valid <= s3_valid;
        end
    end

    // Each stage loads only with its valid bit, so the last digit holds
    always_ff @(posedge clk)
    begin
        if (classify_start_i)
        begin
            s1_win <= s1_next;
        end
        if (s1_valid)
        begin
            s2_win[0] <= pick_later(s1_win[0], s1_win[1]);
            s2_win[1] <= pick_later(s1_win[2], s1_win[3]);
            s2_tail   <= s1_win[4];
        end
        if (s2_valid)
        begin
            s3_win  <= pick_later(s2_win[0], s2_win[1]);
            s3_tail <= s2_tail;
        end
        // Pair 8/9 holds the highest indices, so it is the later side
        if (s3_valid)
        begin
            s4_win <= pick_later(s3_win, s3_tail);
        end
    end

    assign digit_o       = s4_win.idx;
    assign digit_valid_o = s4_valid;

endmodule

//--- src/cnn_receiver.sv
// CNN receiver top joining the sequencer, the pooling path and the argmax
`timescale 1ns/100ps

module cnn_receiver
(
    input  logic                                clk,
    input  logic                                rst,
    input  cnn_dim_pkg::mac_beat_t              mac_i,
    input  cnn_dim_pkg::lane_data_t             bias_q_i,
    output logic [cnn_ctrl_pkg::BIAS_AW-1:0]    bias_addr_o,
    output cnn_dim_pkg::fmap_wr_t               fmap_wr_o,
    output logic                                conv_phase_o,
    output logic [cnn_dim_pkg::CLASS_W-1:0]     digit_o,
    output logic                                digit_valid_o
);

    cnn_dim_pkg::pool_pos_t          pool_pos;
    logic                            score_we;
    logic [cnn_dim_pkg::CLASS_W-1:0] score_idx;
    logic                            classify_start;

    rcv_sequencer u_seq
    (
        .clk              (clk),
        .rst              (rst),
        .mac_valid_i      (mac_i.valid),
        .bias_addr_o      (bias_addr_o),
        .pool_pos_o       (pool_pos),
        .score_we_o       (score_we),
        .score_idx_o      (score_idx),
        .classify_start_o (classify_start),
        .conv_phase_o     (conv_phase_o)
    );

    bias_relu_pool u_pool
    (
        .clk        (clk),
        .rst        (rst),
        .beat_i     (mac_i),
        .bias_i     (bias_q_i),
        .pool_pos_i (pool_pos),
        .fmap_wr_o  (fmap_wr_o)
    );

    // Classifier uses lane 0 of the MAC array and the class's lane of the bias word
    score_argmax u_argmax
    (
        .clk              (clk),
        .rst              (rst),
        .acc_i            (mac_i.acc[0]),
        .bias_i           (bias_q_i[score_idx[cnn_dim_pkg::LANE_W-1:0]]),
        .score_we_i       (score_we),
        .score_idx_i      (score_idx),
        .classify_start_i (classify_start),
        .digit_o          (digit_o),
        .digit_valid_o    (digit_valid_o)
    );

endmodule

//--- tests/tb_cnn_receiver.sv
// Testbench for the CNN receiver with MAC array and bias ROM models driven from a run table
`timescale 1ns/100ps

module tb_cnn_receiver;

    localparam int NUM_ROWS = 4;

    logic                             clk;
    logic                             rst;
    cnn_dim_pkg::mac_beat_t           mac;
    cnn_dim_pkg::lane_data_t          bias_q;
    logic [cnn_ctrl_pkg::BIAS_AW-1:0] bias_addr;
    cnn_dim_pkg::fmap_wr_t            fmap_wr;
    logic                             conv_phase;
    logic [3:0]                       digit;
    logic                             digit_valid;

    // Each run row holds a name, the conv bias word (lane 3 first), the FC bias base
    // where class k gets base+k, the gap flag and the FC lane 0 accumulators (class 9 first)
    string                   row_name  [NUM_ROWS];
    cnn_dim_pkg::lane_data_t row_cbias [NUM_ROWS];
    logic [15:0]             row_fbase [NUM_ROWS];
    logic                    row_gap   [NUM_ROWS];
    logic [9:0][17:0]        row_fcacc [NUM_ROWS];

    cnn_dim_pkg::lane_data_t bias_rom [16];
    cnn_dim_pkg::lane_data_t relu_pix [64];
    string                   cur_name;
    integer                  seed;
    int                      err_cnt;
    int                      fail_cnt;
    int                      wr_cnt;

    cnn_receiver dut
    (
        .clk           (clk),
        .rst           (rst),
        .mac_i         (mac),
        .bias_q_i      (bias_q),
        .bias_addr_o   (bias_addr),
        .fmap_wr_o     (fmap_wr),
        .conv_phase_o  (conv_phase),
        .digit_o       (digit),
        .digit_valid_o (digit_valid)
    );

    // Bias memory answers in the same cycle
    assign bias_q = bias_rom[bias_addr];

    always #50 clk = ~clk;

    task automatic check_value(input string what, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        if (exp_val !== act_val)
        begin
            err_cnt++;
            $display("FAIL %s %s: expected %0h, actual %0h", cur_name, what, exp_val, act_val);
        end
    endtask

    // No beat this cycle, so no write may follow
    task automatic idle_cycle();
        mac.valid = 1'b0;
        @(negedge clk);
        check_value("idle write enable", 1'b0, fmap_wr.en);
    endtask

    // Drive one beat, then look at the write from its accepting edge
    task automatic send_beat(input cnn_dim_pkg::lane_acc_t acc, input logic exp_wr,
                             input logic [3:0] exp_addr, input cnn_dim_pkg::lane_data_t exp_data);
        mac.valid = 1'b1;
        mac.acc   = acc;
        @(negedge clk);
        mac.valid = 1'b0;
        check_value("write enable", exp_wr, fmap_wr.en);
        if (fmap_wr.en)
        begin
            wr_cnt++;
        end
        if (exp_wr)
        begin
            check_value("write address", exp_addr, fmap_wr.addr);
            check_value("write data", exp_data, fmap_wr.data);
        end
    endtask

    task automatic run_row(input int r);
        cnn_dim_pkg::lane_acc_t  acc;
        cnn_dim_pkg::lane_data_t pooled;
        logic [15:0]             sum;
        logic [17:0]             win;
        logic signed [15:0]      score;
        logic signed [15:0]      best_score;
        logic                    fire;
        int                      best_idx;
        int                      x;
        int                      y;
        int                      edges;
        cur_name    = row_name[r];
        wr_cnt      = 0;
        bias_rom[0] = row_cbias[r];
        for (int a = 1; a < 4; a++)
        begin
            for (int l = 0; l < 4; l++)
            begin
                bias_rom[a][l] = row_fbase[r] + 16'((a - 1) * 4 + l);
            end
        end
        for (int p = 0; p < 64; p++)
        begin
            x    = p % 8;
            y    = p / 8;
            fire = (x % 2 == 1) && (y % 2 == 1);
            check_value("conv phase", 1'b1, conv_phase);
            check_value("conv bias address", cnn_ctrl_pkg::BIAS_CONV_ADDR, bias_addr);
            for (int l = 0; l < 4; l++)
            begin
                acc[l] = 18'($random(seed));
                sum    = acc[l][15:0] + row_cbias[r][l];
                relu_pix[p][l] = sum[15] ? 16'h0000 : sum;
                if (fire)
                begin
                    win = 18'(relu_pix[p][l]) + relu_pix[p-1][l]
                        + relu_pix[p-8][l] + relu_pix[p-9][l];
                    pooled[l] = win[17:2];
                end
            end
            send_beat(acc, fire, 4'((y / 2) * 4 + x / 2), pooled);
            if (row_gap[r])
            begin
                repeat (1 + p % 3) idle_cycle();
            end
        end
        check_value("phase after conv", 1'b0, conv_phase);
        check_value("write count", 16, wr_cnt);
        best_idx   = 0;
        best_score = 16'sh8000;
        for (int k = 0; k < 10; k++)
        begin
            check_value("fc phase", 1'b0, conv_phase);
            check_value("fc bias address", cnn_ctrl_pkg::BIAS_FC_BASE + k / 4, bias_addr);
            score = row_fcacc[r][k][15:0] + bias_rom[1 + k / 4][k % 4];
            // Equal scores move the decision to the later class
            if (score >= best_score)
            begin
                best_score = score;
                best_idx   = k;
            end
            for (int l = 0; l < 4; l++)
            begin
                acc[l] = 18'($random(seed));
            end
            acc[0] = row_fcacc[r][k];
            send_beat(acc, 1'b0, 4'h0, '0);
            if (row_gap[r] && k < 9)
            begin
                repeat (2) idle_cycle();
            end
        end
        // Count rising edges after the one that accepted the tenth FC beat
        edges = 0;
        while (!digit_valid && edges < 20)
        begin
            @(negedge clk);
            edges++;
        end
        if (!digit_valid)
        begin
            fail_cnt++;
            $display("Timed out waiting for the digit pulse in %s", cur_name);
        end
        else
        begin
            check_value("digit latency", 5, edges);
            check_value("digit", best_idx, digit);
            @(negedge clk);
            check_value("digit pulse width", 1'b0, digit_valid);
        end
    endtask

    initial
    begin
        clk      = 1'b0;
        rst      = 1'b1;
        mac      = '0;
        seed     = 32'h16d5e557;
        err_cnt  = 0;
        fail_cnt = 0;
        cur_name = "reset";
        for (int a = 0; a < 16; a++)
        begin
            bias_rom[a] = {4{12'hb1a, 4'(a)}};
        end

        row_name[0]  = "b2b_pos_bias";
        row_cbias[0] = {16'h0010, 16'h0100, 16'h0004, 16'h0000};
        row_fbase[0] = 16'h0020;
        row_gap[0]   = 1'b0;
        row_fcacc[0] = {18'd0, 18'd2, 18'd1, 18'd800, 18'd3,
                        18'd7, 18'd40, 18'd12, 18'd900, 18'd5};
        row_name[1]  = "gap_neg_bias";
        row_cbias[1] = {16'hff80, 16'hfff0, 16'h8000, 16'h0040};
        row_fbase[1] = 16'hfc00;
        row_gap[1]   = 1'b1;
        row_fcacc[1] = {18'd1000, 18'd90, 18'd80, 18'd70, 18'd60,
                        18'd50, 18'd40, 18'd30, 18'd20, 18'd10};
        // Classes 3 and 7 tie at 100
        row_name[2]  = "tie_high_index";
        row_cbias[2] = {16'h0001, 16'h0002, 16'h0003, 16'h0004};
        row_fbase[2] = 16'h0000;
        row_gap[2]   = 1'b0;
        row_fcacc[2] = {18'd10, 18'd9, 18'd93, 18'd7, 18'd6,
                        18'd5, 18'd97, 18'd3, 18'd2, 18'd1};
        // All scores are negative and classes 0 and 5 tie at -16
        row_name[3]  = "neg_tie_gap";
        row_cbias[3] = {16'h7fff, 16'hc000, 16'h0000, 16'hfffe};
        row_fbase[3] = 16'hff00;
        row_gap[3]   = 1'b1;
        row_fcacc[3] = {18'h0, 18'h0, 18'h0, 18'h0, 18'h000eb,
                        18'h0, 18'h0, 18'h30010, 18'h0, 18'h000f0};

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("write enable", 1'b0, fmap_wr.en);
        check_value("digit valid", 1'b0, digit_valid);
        check_value("conv phase", 1'b1, conv_phase);
        check_value("bias address", 0, bias_addr);

        // Rows run one after another without reset in between
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_row(r);
        end

        $display("Value mismatches: %0d, other failures: %0d", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
src/cnn_dim_pkg.sv
src/cnn_ctrl_pkg.sv
src/rcv_sequencer.sv
src/bias_relu_pool.sv
src/score_argmax.sv
src/cnn_receiver.sv
tests/tb_cnn_receiver.sv
